// File: icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// default geometry is 1 KB
`define ICACHE_SETS       4   // power of two
`define ICACHE_WAYS       4   // power of two
`define ICACHE_LINE_WORDS 16  // 64-byte line

`define ICACHE_ADDR_W     32
`define ICACHE_WORD_W     32

`endif

// File: icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

    localparam int BYTE_W     = $clog2(`ICACHE_WORD_W / 8);
    localparam int OFFSET_W   = $clog2(`ICACHE_LINE_WORDS);
    localparam int INDEX_W    = $clog2(`ICACHE_SETS);
    localparam int WAY_W      = $clog2(`ICACHE_WAYS);
    localparam int INDEX_LSB  = BYTE_W + OFFSET_W;  // also the line alignment
    localparam int TAG_LSB    = INDEX_LSB + INDEX_W;
    localparam int TAG_W      = `ICACHE_ADDR_W - TAG_LSB;

    typedef logic [TAG_W-1:0]    tag_t;     // 31..8 by default
    typedef logic [INDEX_W-1:0]  index_t;   // 7..6
    typedef logic [OFFSET_W-1:0] offset_t;  // 5..2
    typedef logic [WAY_W-1:0]    way_t;

endpackage

// File: icache_bus_pkg.sv
`include "icache_consts.svh"

package icache_bus_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
    typedef logic [`ICACHE_WORD_W-1:0] word_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_refill_addr,
        st_refill_data,
        st_uncached_addr,
        st_uncached_data,
        st_respond        // s_rvalid high in this state
    } ctrl_state_t;

endpackage

// File: icache_tag_array.sv
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_tag_array
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  index_t req_index,
    input  tag_t   req_tag,
    input  logic   fill_done,
    input  way_t   wr_way,
    output logic   hit,
    output way_t   hit_way,
    output way_t   victim_way
);

    tag_t                    tags     [`ICACHE_SETS][`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0] valid    [`ICACHE_SETS];
    way_t                    fifo_ptr [`ICACHE_SETS];  // next way to replace

    // parallel compare over the indexed set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (valid[req_index][w] && tags[req_index][w] == req_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign victim_way = fifo_ptr[req_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid[s]    <= '0;
                fifo_ptr[s] <= '0;
            end
        end else if (fill_done) begin
            valid[req_index][wr_way] <= 1'b1;
            fifo_ptr[req_index]      <= fifo_ptr[req_index] + 1'b1;  // wraps over the ways
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tags[req_index][wr_way] <= req_tag;
        end
    end

endmodule

// File: icache_data_array.sv
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_data_array
    import icache_pkg::*;
    import icache_bus_pkg::*;
(
    input  logic    clk,
    input  logic    wr_en,
    input  way_t    wr_way,
    input  index_t  req_index,
    input  offset_t wr_offset,
    input  offset_t req_offset,
    input  word_t   m_rdata,
    output word_t   rd_word
);

    localparam int LINE_ADDR_W = INDEX_W + WAY_W + OFFSET_W;
    localparam int DEPTH       = `ICACHE_SETS * `ICACHE_WAYS * `ICACHE_LINE_WORDS;

    word_t                  mem [DEPTH];
    logic [LINE_ADDR_W-1:0] wr_addr;
    logic [LINE_ADDR_W-1:0] rd_addr;

    // set, way, word
    assign wr_addr = {req_index, wr_way, wr_offset};
    assign rd_addr = {req_index, wr_way, req_offset};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= m_rdata;  // one refill beat
        end
    end

    assign rd_word = mem[rd_addr];  // async read

endmodule

// File: icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl
    import icache_pkg::*;
    import icache_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    cache_ena,
    input  logic    s_arvalid,
    input  addr_t   s_araddr,
    input  logic    m_arready,
    input  logic    m_rvalid,
    input  logic    m_rlast,
    input  word_t   m_rdata,
    input  logic    hit,
    input  way_t    hit_way,
    input  way_t    victim_way,
    input  word_t   rd_word,
    output logic    s_rvalid,
    output word_t   s_rdata,
    output logic    m_arvalid,
    output addr_t   m_araddr,
    output index_t  req_index,
    output tag_t    req_tag,
    output offset_t req_offset,
    output logic    fill_done,
    output logic    wr_en,
    output way_t    wr_way,
    output offset_t wr_offset
);

    ctrl_state_t state;
    addr_t       addr_r;
    logic        ena_r;
    way_t        fill_way;   // victim captured at the miss
    offset_t     beat_cnt;
    logic        refill_beat;

    assign req_offset = addr_r[INDEX_LSB-1:BYTE_W];
    assign req_index  = addr_r[TAG_LSB-1:INDEX_LSB];
    assign req_tag    = addr_r[$bits(addr_t)-1:TAG_LSB];

    assign refill_beat = (state == st_refill_data) && m_rvalid;
    assign wr_en       = refill_beat;
    assign wr_offset   = beat_cnt;
    assign fill_done   = refill_beat && m_rlast;  // tag written on the last beat

    // read way, and the write way during a refill
    assign wr_way = (state == st_lookup) ? hit_way : fill_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            s_rvalid  <= 1'b0;
            m_arvalid <= 1'b0;
            beat_cnt  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (s_arvalid) state <= st_lookup;
                end
                st_lookup: begin
                    if (!ena_r) begin
                        m_arvalid <= 1'b1;
                        state     <= st_uncached_addr;
                    end else if (hit) begin
                        s_rvalid <= 1'b1;
                        state    <= st_respond;
                    end else begin
                        m_arvalid <= 1'b1;
                        beat_cnt  <= '0;
                        state     <= st_refill_addr;
                    end
                end
                st_refill_addr: begin
                    if (m_arready) begin
                        m_arvalid <= 1'b0;
                        state     <= st_refill_data;
                    end
                end
                st_refill_data: begin
                    if (m_rvalid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (m_rlast) state <= st_lookup;  // re-read, now a hit
                    end
                end
                st_uncached_addr: begin
                    if (m_arready) begin
                        m_arvalid <= 1'b0;
                        state     <= st_uncached_data;
                    end
                end
                st_uncached_data: begin
                    if (m_rvalid) begin
                        s_rvalid <= 1'b1;
                        state    <= st_respond;
                    end
                end
                st_respond: begin
                    s_rvalid <= 1'b0;
                    state    <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && s_arvalid) begin
            addr_r <= s_araddr;
            ena_r  <= cache_ena;
        end
        if (state == st_lookup) begin
            if (!ena_r) begin
                m_araddr <= addr_r;  // exact word
            end else if (hit) begin
                s_rdata <= rd_word;
            end else begin
                m_araddr <= {addr_r[$bits(addr_t)-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
                fill_way <= victim_way;
            end
        end
        if (state == st_uncached_data && m_rvalid) begin
            s_rdata <= m_rdata;
        end
    end

endmodule

// File: icache_top.sv
`timescale 1ns/1ns

module icache_top
    import icache_pkg::*;
    import icache_bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  cache_ena,
    input  logic  s_arvalid,
    input  addr_t s_araddr,
    output logic  s_rvalid,
    output word_t s_rdata,
    output logic  m_arvalid,
    output addr_t m_araddr,
    input  logic  m_arready,
    input  logic  m_rvalid,
    input  logic  m_rlast,
    input  word_t m_rdata
);

    index_t  req_index;
    tag_t    req_tag;
    offset_t req_offset;
    logic    hit;
    way_t    hit_way;
    way_t    victim_way;
    logic    fill_done;
    logic    wr_en;
    way_t    wr_way;
    offset_t wr_offset;
    word_t   rd_word;

    icache_ctrl i_icache_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cache_ena  (cache_ena),
        .s_arvalid  (s_arvalid),
        .s_araddr   (s_araddr),
        .m_arready  (m_arready),
        .m_rvalid   (m_rvalid),
        .m_rlast    (m_rlast),
        .m_rdata    (m_rdata),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .rd_word    (rd_word),
        .s_rvalid   (s_rvalid),
        .s_rdata    (s_rdata),
        .m_arvalid  (m_arvalid),
        .m_araddr   (m_araddr),
        .req_index  (req_index),
        .req_tag    (req_tag),
        .req_offset (req_offset),
        .fill_done  (fill_done),
        .wr_en      (wr_en),
        .wr_way     (wr_way),
        .wr_offset  (wr_offset)
    );

    icache_tag_array i_icache_tag_array (
        .clk        (clk),
        .rst        (rst),
        .req_index  (req_index),
        .req_tag    (req_tag),
        .fill_done  (fill_done),
        .wr_way     (wr_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    icache_data_array i_icache_data_array (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_way     (wr_way),
        .req_index  (req_index),
        .wr_offset  (wr_offset),
        .req_offset (req_offset),
        .m_rdata    (m_rdata),
        .rd_word    (rd_word)
    );

endmodule

// File: tb_icache_assertions.sv
`timescale 1ns/1ns

module tb_icache_assertions
    import icache_bus_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  s_rvalid,
    input logic  m_arvalid,
    input addr_t m_araddr,
    input logic  m_arready
);

    // address phase held until the bus takes it
    a_ar_stable: assert property (
        @(posedge clk) disable iff (rst)
        (m_arvalid && !m_arready) |=> (m_arvalid && $stable(m_araddr))
    ) else $error("m_arvalid or m_araddr changed before m_arready");

    a_rvalid_pulse: assert property (
        @(posedge clk) disable iff (rst)
        s_rvalid |=> !s_rvalid
    ) else $error("s_rvalid high for two cycles in a row");

    a_ar_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !m_arvalid
    ) else $error("m_arvalid high in the first cycle after reset");

endmodule

bind icache_top tb_icache_assertions i_tb_icache_assertions (.*);

// File: tb_icache.sv
`timescale 1ns/1ns
`include "icache_consts.svh"

module tb_icache
    import icache_pkg::*;
    import icache_bus_pkg::*;
();

    localparam int HIT_CYCLES = 3;      // idle edge, lookup edge, then the pulse is seen
    localparam int MAX_CYCLES = 20000;  // 210 reads at up to ~60 cycles per refill

    logic  clk;
    logic  rst;
    logic  cache_ena;
    logic  s_arvalid;
    logic  s_rvalid;
    logic  m_arvalid;
    logic  m_arready;
    logic  m_rvalid;
    logic  m_rlast;
    addr_t s_araddr;
    addr_t m_araddr;
    word_t s_rdata;
    word_t m_rdata;

    int    errors;
    int    n_checks;
    int    n_tests;
    int    cycles;
    int    burst_len;  // beats for the next bus request
    int    bus_reqs;   // accepted bus addresses
    int    bus_beats;  // beats taken before the answer
    addr_t bus_addr;

    tag_t                    ref_tag   [`ICACHE_SETS][`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0] ref_valid [`ICACHE_SETS];
    way_t                    ref_ptr   [`ICACHE_SETS];

    icache_top i_icache_top (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles == MAX_CYCLES) begin
            $display("run timed out after %0d cycles with tests still running", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (m_rvalid && !s_rvalid) bus_beats++;
    end

    function automatic word_t mem_word(input addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    // tag 31..8, set 7..6
    function automatic logic predict_miss(input addr_t a);
        logic miss;
        miss = 1'b1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (ref_valid[a[7:6]][w] && ref_tag[a[7:6]][w] == a[31:8]) miss = 1'b0;
        end
        return miss;
    endfunction

    function automatic void ref_fill(input addr_t a);
        index_t s;
        s = a[7:6];
        ref_tag[s][ref_ptr[s]]   = a[31:8];
        ref_valid[s][ref_ptr[s]] = 1'b1;
        ref_ptr[s]               = ref_ptr[s] + 1'b1;  // oldest way next
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic log_result(input string name, input int errs_before);
        n_tests++;
        $display("%s: %s", name, (errors == errs_before) ? "ok" : "has errors");
    endtask

    // bus memory with random address and beat delays
    task automatic serve_burst();
        addr_t a;
        int    n;
        repeat ($urandom_range(3, 0)) @(posedge clk);
        m_arready <= 1'b1;
        @(posedge clk);  // accepted here
        m_arready <= 1'b0;
        a = m_araddr;
        n = burst_len;
        bus_reqs++;
        bus_addr  = a;
        bus_beats = 0;
        for (int b = 0; b < n; b++) begin
            repeat ($urandom_range(2, 0)) begin
                m_rvalid <= 1'b0;
                @(posedge clk);
            end
            m_rvalid <= 1'b1;
            m_rdata  <= mem_word(a + 4 * b);
            m_rlast  <= (b == n - 1);
            @(posedge clk);
        end
        m_rvalid  <= 1'b0;
        m_rlast   <= 1'b0;
    endtask

    initial begin
        forever begin
            @(posedge clk);
            if (m_arvalid && !rst) serve_burst();
        end
    end

    task automatic cpu_read(input addr_t addr, input logic ena, output word_t data,
                            output int lat);
        @(posedge clk);
        burst_len = ena ? `ICACHE_LINE_WORDS : 1;
        cache_ena <= ena;
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!s_rvalid);
        data = s_rdata;
        s_arvalid <= 1'b0;  // right after the pulse
    endtask

    task automatic checked_read(input addr_t addr, input logic ena, input logic exp_miss,
                                input string msg);
        word_t data;
        int    lat;
        int    reqs_before;
        reqs_before = bus_reqs;
        cpu_read(addr, ena, data, lat);
        check(data, mem_word(addr), {msg, ", data"});
        check(bus_reqs - reqs_before, 32'(exp_miss), {msg, ", bus requests"});
        if (!exp_miss) begin
            check(lat, HIT_CYCLES, {msg, ", hit latency"});
        end else begin
            check(bus_addr, ena ? {addr[31:6], 6'b0} : addr, {msg, ", bus address"});
            check(bus_beats, ena ? `ICACHE_LINE_WORDS : 1, {msg, ", beats"});
        end
        if (ena && exp_miss) ref_fill(addr);
    endtask

    task automatic idle_after_reset();
        int   e0;
        logic busy;
        e0   = errors;
        busy = 1'b0;
        repeat (10) begin
            @(posedge clk);
            busy = busy | s_rvalid | m_arvalid;
        end
        check(32'(busy), 0, "s_rvalid or m_arvalid high with no request");
        log_result("after reset", e0);
    endtask

    task automatic miss_then_hit();
        int e0;
        e0 = errors;
        checked_read(32'h0000_2088, 1'b1, 1'b1, "cold miss");
        checked_read(32'h0000_20bc, 1'b1, 1'b0, "same line");
        log_result("miss then hit", e0);
    endtask

    task automatic uncached_read();
        int e0;
        e0 = errors;
        checked_read(32'h0000_30c4, 1'b0, 1'b1, "uncached");
        checked_read(32'h0000_30c8, 1'b1, 1'b1, "cached after uncached");
        log_result("uncached read", e0);
    endtask

    // five lines of set 1, tags 0x40 to 0x44
    task automatic fifo_replacement();
        int e0;
        e0 = errors;
        for (int k = 0; k < 5; k++) begin
            checked_read(32'h0000_4040 + 32'h104 * k, 1'b1, 1'b1, "fifo fill");
        end
        checked_read(32'h0000_4060, 1'b1, 1'b1, "first line again");
        checked_read(32'h0000_427c, 1'b1, 1'b0, "third line again");
        log_result("fifo replacement", e0);
    endtask

    task automatic random_reads();
        int    e0;
        addr_t a;
        logic  ena;
        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            a   = 32'h0001_0000 | ($urandom() & 32'h0000_0ffc);
            ena = (i % 8 != 7);
            checked_read(a, ena, !ena || predict_miss(a), "random read");
        end
        log_result("random reads", e0);
    endtask

    initial begin
        void'($urandom(32'h54639be3));
        rst       = 1'b1;
        cache_ena = 1'b1;
        s_arvalid = 1'b0;
        s_araddr  = '0;
        m_arready = 1'b0;
        m_rvalid  = 1'b0;
        m_rlast   = 1'b0;
        m_rdata   = '0;
        burst_len = `ICACHE_LINE_WORDS;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            ref_valid[s] = '0;
            ref_ptr[s]   = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        idle_after_reset();
        miss_then_hit();
        uncached_read();
        fifo_replacement();
        random_reads();
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+.
icache_pkg.sv
icache_bus_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_ctrl.sv
icache_top.sv
tb_icache_assertions.sv
tb_icache.sv

// File: run.sh
#!/usr/bin/env bash
# builds the icache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
        -f all.f --top-module tb_icache; then
    echo "verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/Vtb_icache); then
    echo "$out"
    echo "simulation exited with an error status"
    exit 1
fi
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
